//--- verilog/cpu16_pkg.sv
package cpu16_pkg;

	// data, instruction and address words
	typedef logic [15:0] word_t;
	typedef logic [2:0] reg_addr_t;
	typedef logic [15:0] pc_t;

	// major opcode, bits 15..11
	typedef logic [4:0] opcode_t;

	localparam opcode_t op_li = 5'b01101;
	localparam opcode_t op_shift = 5'b00110; // sll lives here
	localparam opcode_t op_rrr = 5'b11100; // addu lives here
	localparam opcode_t op_move = 5'b01111;
	localparam opcode_t op_addiu = 5'b01001;
	localparam opcode_t op_bnez = 5'b00101;
	localparam opcode_t op_nop = 5'b00001;

	// function fields
	localparam logic [1:0] funct_sll = 2'b00; // bits 1..0
	localparam logic [1:0] funct_addu = 2'b01; // bits 1..0
	localparam logic [4:0] funct_move = 5'b00000; // bits 4..0
	localparam logic [10:0] funct_nop = 11'b100_0000_0000; // bits 10..0

	// canonical empty slot
	localparam word_t nop_word = {op_nop, funct_nop};

endpackage

//--- verilog/inst_fetch.sv
`timescale 1ns/1ns

module inst_fetch #(
	parameter int queue_depth = 4
) (
	input logic clk,
	input logic pclk,
	output cpu16_pkg::pc_t imem_addr,
	input cpu16_pkg::word_t imem_data,
	output logic push,
	output cpu16_pkg::word_t push_inst,
	output cpu16_pkg::pc_t push_pc,
	input logic credit_return,
	input logic pc_switch_ctrl,
	input cpu16_pkg::pc_t new_pc,
	input logic clear_flow
);
	localparam int cred_w = $clog2(queue_depth + 1);

	cpu16_pkg::pc_t pc;
	logic [cred_w-1:0] credits; // free queue slots not yet claimed
	logic fetch_go;

	assign imem_addr = pc; // memory answers in the same cycle

	// no fetch while a redirect is pending, the word would be stale
	assign fetch_go = (credits != '0) && !clear_flow;

	always_ff @(posedge clk or posedge pclk) begin
		if (pclk) begin
			pc <= '0;
			credits <= cred_w'(queue_depth);
			push <= 1'b0;
		end else begin
			if (clear_flow) begin
				credits <= cred_w'(queue_depth); // queue is emptied on the same edge
			end else begin
				credits <= credits - cred_w'(fetch_go) + cred_w'(credit_return);
			end
			push <= fetch_go;
			if (pc_switch_ctrl) begin
				pc <= new_pc;
			end else if (fetch_go) begin
				pc <= pc + 16'd1;
			end
		end
	end

	// word and its address, presented with push one cycle later
	always_ff @(posedge clk) begin
		if (fetch_go) begin
			push_inst <= imem_data;
			push_pc <= pc;
		end
	end

	// returns and resets must never leave more credits than slots
	a_credit_max: assert property (@(posedge clk) disable iff (pclk)
		credits <= cred_w'(queue_depth))
		else $error("inst_fetch: credit count %0d above queue depth", credits);

endmodule

//--- verilog/issue_queue.sv
`timescale 1ns/1ns

module issue_queue #(
	parameter int queue_depth = 4
) (
	input logic clk,
	input logic pclk,
	input logic push,
	input cpu16_pkg::word_t push_inst,
	input cpu16_pkg::pc_t push_pc,
	output logic pop_valid,
	output cpu16_pkg::word_t pop_inst,
	output cpu16_pkg::pc_t pop_pc,
	output logic credit_return,
	input logic clear_flow
);
	localparam int ptr_w = $clog2(queue_depth);
	localparam int cnt_w = $clog2(queue_depth + 1);

	cpu16_pkg::word_t inst_mem [queue_depth];
	cpu16_pkg::pc_t pc_mem [queue_depth];
	logic [ptr_w-1:0] wr_ptr;
	logic [ptr_w-1:0] rd_ptr;
	logic [cnt_w-1:0] count;
	logic do_push;
	logic do_pop;

	// wrap at the depth, which need not be a power of two
	function automatic logic [ptr_w-1:0] ptr_inc(input logic [ptr_w-1:0] p);
		if (p == ptr_w'(queue_depth - 1)) begin
			return '0;
		end
		return p + 1'b1;
	endfunction

	assign pop_valid = (count != '0);
	assign pop_inst = inst_mem[rd_ptr];
	assign pop_pc = pc_mem[rd_ptr];

	// execute takes every valid head unless a flush is on its way
	assign do_pop = pop_valid && !clear_flow;
	assign do_push = push && !clear_flow;

	always_ff @(posedge clk or posedge pclk) begin
		if (pclk) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
			credit_return <= 1'b0;
		end else if (clear_flow) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
			credit_return <= 1'b0; // fetch reloads its credits itself
		end else begin
			if (do_push) begin
				wr_ptr <= ptr_inc(wr_ptr);
			end
			if (do_pop) begin
				rd_ptr <= ptr_inc(rd_ptr);
			end
			count <= count + cnt_w'(do_push) - cnt_w'(do_pop);
			credit_return <= do_pop; // one credit per pop
		end
	end

	always_ff @(posedge clk) begin
		if (do_push) begin
			inst_mem[wr_ptr] <= push_inst;
			pc_mem[wr_ptr] <= push_pc;
		end
	end

	// fetch must hold a credit for every push
	a_no_overflow: assert property (@(posedge clk) disable iff (pclk)
		!(push && count == cnt_w'(queue_depth)))
		else $error("issue_queue: push into a full queue, credit protocol broken");

endmodule

//--- verilog/reg_file.sv
`timescale 1ns/1ns

module reg_file (
	input logic clk,
	input logic pclk,
	input cpu16_pkg::reg_addr_t rd_addr_a,
	output cpu16_pkg::word_t rd_data_a,
	input cpu16_pkg::reg_addr_t rd_addr_b,
	output cpu16_pkg::word_t rd_data_b,
	input logic write_reg_ctrl,
	input cpu16_pkg::reg_addr_t write_reg_addr,
	input cpu16_pkg::word_t write_reg_data
);
	cpu16_pkg::word_t regs [8]; // r0..r7, all general purpose

	// read ports, no write bypass here
	assign rd_data_a = regs[rd_addr_a];
	assign rd_data_b = regs[rd_addr_b];

	always_ff @(posedge clk or posedge pclk) begin
		if (pclk) begin
			for (int i = 0; i < 8; i++) begin
				regs[i] <= '0;
			end
		end else if (write_reg_ctrl) begin
			regs[write_reg_addr] <= write_reg_data;
		end
	end

endmodule

//--- verilog/exe_unit.sv
`timescale 1ns/1ns

module exe_unit (
	input logic clk,
	input logic pclk,
	input logic pop_valid,
	input cpu16_pkg::word_t pop_inst,
	input cpu16_pkg::pc_t pop_pc,
	output cpu16_pkg::reg_addr_t rd_addr_a,
	output cpu16_pkg::reg_addr_t rd_addr_b,
	input cpu16_pkg::word_t rd_data_a,
	input cpu16_pkg::word_t rd_data_b,
	input logic fwd_ctrl,
	input cpu16_pkg::reg_addr_t fwd_addr,
	input cpu16_pkg::word_t fwd_data,
	input logic clear_flow,
	output cpu16_pkg::word_t alu_res,
	output logic alu_flag,
	output logic reg_wr,
	output cpu16_pkg::reg_addr_t reg_addr,
	output cpu16_pkg::word_t opn,
	output cpu16_pkg::pc_t pc_input
);
	cpu16_pkg::opcode_t op;
	cpu16_pkg::reg_addr_t rx;
	cpu16_pkg::reg_addr_t ry;
	cpu16_pkg::reg_addr_t rz;
	cpu16_pkg::word_t imm_s;
	cpu16_pkg::word_t opnd_a;
	cpu16_pkg::word_t opnd_b;
	logic [3:0] shamt;
	logic dec_wr;
	logic dec_flag;
	cpu16_pkg::reg_addr_t dec_addr;
	cpu16_pkg::word_t dec_res;
	logic slot_go;

	assign op = pop_inst[15:11];
	assign rx = pop_inst[10:8];
	assign ry = pop_inst[7:5];
	assign rz = pop_inst[4:2];
	assign imm_s = {{8{pop_inst[7]}}, pop_inst[7:0]};
	assign shamt = (pop_inst[4:2] == 3'd0) ? 4'd8 : {1'b0, pop_inst[4:2]}; // 0 encodes 8

	assign rd_addr_a = rx;
	assign rd_addr_b = ry;

	// newest value wins: own pending result, then the write-back port, then the file
	assign opnd_a = (reg_wr && reg_addr == rx) ? alu_res :
			(fwd_ctrl && fwd_addr == rx) ? fwd_data : rd_data_a;
	assign opnd_b = (reg_wr && reg_addr == ry) ? alu_res :
			(fwd_ctrl && fwd_addr == ry) ? fwd_data : rd_data_b;

	always_comb begin
		dec_wr = 1'b0;
		dec_flag = 1'b0;
		dec_addr = rx;
		dec_res = '0;
		case (op)
			cpu16_pkg::op_li: begin
				dec_wr = 1'b1;
				dec_res = {8'h00, pop_inst[7:0]}; // zero extended
			end
			cpu16_pkg::op_shift: begin
				if (pop_inst[1:0] == cpu16_pkg::funct_sll) begin
					dec_wr = 1'b1;
					dec_res = opnd_b << shamt;
				end
			end
			cpu16_pkg::op_rrr: begin
				if (pop_inst[1:0] == cpu16_pkg::funct_addu) begin
					dec_wr = 1'b1;
					dec_addr = rz; // three-register form writes rz
					dec_res = opnd_a + opnd_b;
				end
			end
			cpu16_pkg::op_move: begin
				if (pop_inst[4:0] == cpu16_pkg::funct_move) begin
					dec_wr = 1'b1;
					dec_res = opnd_b;
				end
			end
			cpu16_pkg::op_addiu: begin
				dec_wr = 1'b1;
				dec_res = opnd_a + imm_s;
			end
			cpu16_pkg::op_bnez: begin
				dec_flag = (opnd_a != '0);
				dec_res = pop_pc + 16'd1 + imm_s; // target relative to next pc
			end
			default: begin
			end
		endcase
	end

	assign slot_go = pop_valid && !clear_flow;

	always_ff @(posedge clk or posedge pclk) begin
		if (pclk) begin
			reg_wr <= 1'b0;
			alu_flag <= 1'b0;
			opn <= cpu16_pkg::nop_word;
		end else if (slot_go) begin
			reg_wr <= dec_wr;
			alu_flag <= dec_flag;
			opn <= pop_inst;
		end else begin
			// empty or flushed slot
			reg_wr <= 1'b0;
			alu_flag <= 1'b0;
			opn <= cpu16_pkg::nop_word;
		end
	end

	always_ff @(posedge clk) begin
		alu_res <= dec_res;
		reg_addr <= dec_addr;
		pc_input <= pop_pc;
	end

endmodule

//--- verilog/exe_wb.sv
`timescale 1ns/1ns

module exe_wb (
	input cpu16_pkg::word_t alu_res,
	input logic alu_flag,
	input logic reg_wr,
	input cpu16_pkg::reg_addr_t reg_addr,
	input cpu16_pkg::word_t opn,
	input cpu16_pkg::pc_t pc_input,
	input logic clk,
	input logic pclk,
	output logic pc_switch_ctrl,
	output cpu16_pkg::pc_t new_pc,
	output logic clear_flow,
	output logic write_reg_ctrl,
	output cpu16_pkg::reg_addr_t write_reg_addr,
	output cpu16_pkg::word_t write_reg_data
);

	always_ff @(posedge clk or posedge pclk) begin
		if (pclk) begin
			pc_switch_ctrl <= 1'b0;
			clear_flow <= 1'b0;
			write_reg_ctrl <= 1'b0;
		end else begin
			pc_switch_ctrl <= 1'b0;
			clear_flow <= 1'b0;
			write_reg_ctrl <= 1'b0;
			// the slot behind a taken branch is already dead
			if (!clear_flow) begin
				case (opn[15:11])
					cpu16_pkg::op_li, cpu16_pkg::op_addiu: begin
						write_reg_ctrl <= reg_wr;
					end
					cpu16_pkg::op_shift: begin
						write_reg_ctrl <= reg_wr && (opn[1:0] == cpu16_pkg::funct_sll);
					end
					cpu16_pkg::op_rrr: begin
						write_reg_ctrl <= reg_wr && (opn[1:0] == cpu16_pkg::funct_addu);
					end
					cpu16_pkg::op_move: begin
						write_reg_ctrl <= reg_wr && (opn[4:0] == cpu16_pkg::funct_move);
					end
					cpu16_pkg::op_bnez: begin
						pc_switch_ctrl <= alu_flag; // taken only
						clear_flow <= alu_flag;
					end
					default: begin // nop and unknown words
					end
				endcase
			end
		end
	end

	always_ff @(posedge clk) begin
		write_reg_addr <= reg_addr;
		write_reg_data <= alu_res;
		new_pc <= alu_res; // branch target rides on alu_res
	end

	a_one_action: assert property (@(posedge clk) disable iff (pclk)
		!(write_reg_ctrl && pc_switch_ctrl))
		else $error("exe_wb: register write and redirect in the same cycle");

endmodule

//--- verilog/cpu16_core.sv
`timescale 1ns/1ns

module cpu16_core #(
	parameter int queue_depth = 4
) (
	input logic clk,
	input logic pclk,
	output cpu16_pkg::pc_t imem_addr,
	input cpu16_pkg::word_t imem_data,
	output logic write_reg_ctrl,
	output cpu16_pkg::reg_addr_t write_reg_addr,
	output cpu16_pkg::word_t write_reg_data,
	output logic pc_switch_ctrl,
	output cpu16_pkg::pc_t new_pc
);
	// fetch to queue
	logic push;
	cpu16_pkg::word_t push_inst;
	cpu16_pkg::pc_t push_pc;
	logic credit_return;

	// queue to execute
	logic pop_valid;
	cpu16_pkg::word_t pop_inst;
	cpu16_pkg::pc_t pop_pc;

	// execute to register file and write-back
	cpu16_pkg::reg_addr_t rd_addr_a;
	cpu16_pkg::reg_addr_t rd_addr_b;
	cpu16_pkg::word_t rd_data_a;
	cpu16_pkg::word_t rd_data_b;
	cpu16_pkg::word_t alu_res;
	logic alu_flag;
	logic reg_wr;
	cpu16_pkg::reg_addr_t reg_addr;
	cpu16_pkg::word_t opn;
	cpu16_pkg::pc_t pc_input;
	logic clear_flow;

	inst_fetch #(.queue_depth(queue_depth)) fetch0 (
		.clk, .pclk, .imem_addr, .imem_data,
		.push, .push_inst, .push_pc, .credit_return,
		.pc_switch_ctrl, .new_pc, .clear_flow
	);

	issue_queue #(.queue_depth(queue_depth)) queue0 (
		.clk, .pclk, .push, .push_inst, .push_pc,
		.pop_valid, .pop_inst, .pop_pc, .credit_return, .clear_flow
	);

	exe_unit exe0 (
		.clk, .pclk, .pop_valid, .pop_inst, .pop_pc,
		.rd_addr_a, .rd_addr_b, .rd_data_a, .rd_data_b,
		.fwd_ctrl(write_reg_ctrl), .fwd_addr(write_reg_addr), .fwd_data(write_reg_data),
		.clear_flow, .alu_res, .alu_flag, .reg_wr, .reg_addr, .opn, .pc_input
	);

	exe_wb wb0 (
		.alu_res, .alu_flag, .reg_wr, .reg_addr, .opn, .pc_input, .clk, .pclk,
		.pc_switch_ctrl, .new_pc, .clear_flow,
		.write_reg_ctrl, .write_reg_addr, .write_reg_data
	);

	reg_file rf0 (
		.clk, .pclk, .rd_addr_a, .rd_data_a, .rd_addr_b, .rd_data_b,
		.write_reg_ctrl, .write_reg_addr, .write_reg_data
	);

endmodule

//--- tests/cpu16_tb.sv
`timescale 1ns/1ns

module cpu16_tb;

	localparam int prog_len = 48;
	localparam logic [4:0] op_li = 5'b01101;
	localparam logic [4:0] op_shift = 5'b00110;
	localparam logic [4:0] op_rrr = 5'b11100;
	localparam logic [4:0] op_move = 5'b01111;
	localparam logic [4:0] op_addiu = 5'b01001;
	localparam logic [4:0] op_bnez = 5'b00101;
	localparam logic [15:0] nop_w = {5'b00001, 11'b100_0000_0000};

	logic clk;
	logic pclk;
	logic [15:0] imem_addr;
	logic [15:0] imem_data;
	logic write_reg_ctrl;
	logic [2:0] write_reg_addr;
	logic [15:0] write_reg_data;
	logic pc_switch_ctrl;
	logic [15:0] new_pc;

	logic [31:0] seed;
	logic [15:0] prog [prog_len];
	logic [15:0] model_regs [8];
	logic [2:0] exp_wr_addr [$];
	logic [15:0] exp_wr_data [$];
	logic [15:0] exp_tgt [$];
	int wr_seen;
	int br_seen;

	cpu16_core #(.queue_depth(4)) dut0 (
		.clk, .pclk, .imem_addr, .imem_data,
		.write_reg_ctrl, .write_reg_addr, .write_reg_data,
		.pc_switch_ctrl, .new_pc
	);

	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	function automatic logic [31:0] next_rand();
		seed = seed * 32'd1664525 + 32'd1013904223;
		return seed;
	endfunction

	// past the end of the program the memory reads as NOP
	function automatic logic [15:0] imem_word(input logic [15:0] addr);
		if (addr < 16'(prog_len)) begin
			return prog[addr[5:0]];
		end
		return nop_w;
	endfunction

	// combinational memory, driven away from the rising edge
	always @(negedge clk) begin
		imem_data = imem_word(imem_addr);
	end

	task automatic abort_run();
		$display("TEST FAILED");
		$fatal(1);
	endtask

	task automatic check_value(input string name, input logic [15:0] got,
			input logic [15:0] exp);
		if (got !== exp) begin
			$display("MISMATCH at %0t ns: %s is %h, expected %h", $time, name, got, exp);
			abort_run();
		end
	endtask

	task automatic build_program();
		logic [31:0] r;
		logic [31:0] f;
		logic [7:0] off;
		for (int i = 0; i < prog_len; i++) begin
			r = next_rand();
			f = next_rand();
			case (r[31:29])
				3'd0: prog[i] = {op_li, f[31:29], f[22:15]};
				3'd1: prog[i] = {op_addiu, f[31:29], f[22:15]};
				3'd2: prog[i] = {op_shift, f[31:29], f[28:26], f[25:23], 2'b00};
				3'd3: prog[i] = {op_rrr, f[31:29], f[28:26], f[25:23], 2'b01};
				3'd4: prog[i] = {op_move, f[31:29], f[28:26], 5'b00000};
				3'd5: begin
					off = {6'b0, f[16:15]}; // short hops keep most of the program alive
					if (i + 1 + int'(off) > prog_len) begin
						off = 8'(prog_len - 1 - i);
					end
					prog[i] = {op_bnez, f[31:29], off};
				end
				3'd6: prog[i] = nop_w;
				default: begin
					prog[i] = f[31:16]; // raw word, decoded like any other
					if (f[31:27] == op_bnez) begin
						prog[i] = nop_w; // a backward branch could loop forever
					end
				end
			endcase
		end
	endtask

	task automatic model_write(input logic [2:0] addr, input logic [15:0] val);
		model_regs[addr] = val;
		exp_wr_addr.push_back(addr);
		exp_wr_data.push_back(val);
	endtask

	// in-order reference, straight from the instruction table
	task automatic run_model();
		logic [15:0] w;
		logic [15:0] simm;
		logic [3:0] sa;
		int pc;
		for (int i = 0; i < 8; i++) begin
			model_regs[i] = '0;
		end
		pc = 0;
		while (pc < prog_len) begin
			w = prog[pc];
			simm = {{8{w[7]}}, w[7:0]};
			sa = (w[4:2] == 3'd0) ? 4'd8 : {1'b0, w[4:2]};
			pc = pc + 1;
			case (w[15:11])
				op_li: model_write(w[10:8], {8'h00, w[7:0]});
				op_addiu: model_write(w[10:8], model_regs[w[10:8]] + simm);
				op_shift: begin
					if (w[1:0] == 2'b00) begin
						model_write(w[10:8], model_regs[w[7:5]] << sa);
					end
				end
				op_rrr: begin
					if (w[1:0] == 2'b01) begin
						model_write(w[4:2], model_regs[w[10:8]] + model_regs[w[7:5]]);
					end
				end
				op_move: begin
					if (w[4:0] == 5'b00000) begin
						model_write(w[10:8], model_regs[w[7:5]]);
					end
				end
				op_bnez: begin
					if (model_regs[w[10:8]] != 16'h0000) begin
						exp_tgt.push_back(16'(pc) + simm);
						pc = int'(16'(pc) + simm);
					end
				end
				default: begin
				end
			endcase
		end
	endtask

	task automatic observe_outputs();
		if (write_reg_ctrl) begin
			if (wr_seen >= exp_wr_addr.size()) begin
				$display("unexpected register write to r%0d at %0t ns", write_reg_addr, $time);
				abort_run();
			end else begin
				check_value("write_reg_addr", 16'(write_reg_addr), 16'(exp_wr_addr[wr_seen]));
				check_value("write_reg_data", write_reg_data, exp_wr_data[wr_seen]);
				wr_seen++;
			end
		end
		if (pc_switch_ctrl) begin
			if (br_seen >= exp_tgt.size()) begin
				$display("unexpected redirect to %h at %0t ns", new_pc, $time);
				abort_run();
			end else begin
				check_value("new_pc", new_pc, exp_tgt[br_seen]);
				br_seen++;
			end
		end
	endtask

	initial begin
		int cycles;
		int limit;
		pclk = 1'b1;
		imem_data = nop_w;
		seed = 32'h7b75_852c;
		wr_seen = 0;
		br_seen = 0;
		build_program();
		run_model();

		repeat (16) @(negedge clk);
		check_value("write_reg_ctrl", 16'(write_reg_ctrl), 16'h0000);
		check_value("pc_switch_ctrl", 16'(pc_switch_ctrl), 16'h0000);
		check_value("imem_addr", imem_addr, 16'h0000);
		pclk = 1'b0;

		// generous bound, a lost credit would stall fetch for good
		limit = prog_len * 20 + 100;
		cycles = 0;
		while (wr_seen < exp_wr_addr.size() || br_seen < exp_tgt.size()) begin
			@(negedge clk);
			observe_outputs();
			cycles++;
			if (cycles > limit) begin
				$display("timeout after %0d cycles: %0d of %0d writes, %0d of %0d redirects",
					cycles, wr_seen, exp_wr_addr.size(), br_seen, exp_tgt.size());
				abort_run();
			end
		end

		// any extra write or redirect here is caught as unexpected
		repeat (20) begin
			@(negedge clk);
			observe_outputs();
		end

		$display("TEST OK");
		$finish;
	end

endmodule

//--- cpu16.f
verilog/cpu16_pkg.sv
verilog/inst_fetch.sv
verilog/issue_queue.sv
verilog/reg_file.sv
verilog/exe_unit.sv
verilog/exe_wb.sv
verilog/cpu16_core.sv
tests/cpu16_tb.sv

//--- Makefile
VERILATOR ?= verilator
TOP ?= cpu16_tb
FILELIST ?= cpu16.f
OBJ_DIR ?= obj_dir
VFLAGS ?= --binary --timing --assert -Wno-fatal

SOURCES := $(shell grep -v '^+' $(FILELIST))
SIM := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: $(SIM)

# rebuilt only when a source or the file list changes
$(SIM): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

# exit status of the simulator is the pass or fail result
run: $(SIM)
	./$(SIM)

clean:
	rm -rf $(OBJ_DIR)
